// File: all.f
design/siggen_pkg.sv
design/spi_frame_if.sv
design/spi_slave.sv
design/command_decoder.sv
design/dds_bank.sv
design/pwm_bank.sv
design/freq_counter.sv
design/siggen_top.sv
dv/tb_clock.sv
dv/siggen_tb.sv

// File: Makefile
# Verilator flow for the signal generator testbench

VERILATOR  ?= verilator
TOP        ?= siggen_tb
FLIST      ?= all.f
FCLK       ?= 400
BUILD      ?= obj_dir
SIM_FLAGS  ?= -Wno-fatal
LINT_FLAGS ?= -Wall
PASS_TEXT  := ALL TESTS PASSED

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) -f $(FLIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary --timing --assert $(SIM_FLAGS) -f $(FLIST) \
		--top-module $(TOP) -GFCLK=$(FCLK) -Mdir $(BUILD)
	@out="$$($(BUILD)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD)

// File: dv/siggen_tb.sv
`default_nettype none

module siggen_tb
    import siggen_pkg::*;
#(
    parameter int FCLK = 400
);

    localparam logic [31:0] MCLK      = 32'd125_000_000;
    localparam int          half_clks = 8;               // sck level hold in clocks
    localparam int          per0      = 8;               // freq_in periods in clocks
    localparam int          per1      = 20;
    localparam word_t       dds_test_code = 32'h1000_0000;
    // about 1460 spi bits of 16 clocks each taken twice over, plus the counter gates
    localparam int          max_cycles = 56000 + 10 * FCLK;

    logic       clk;
    logic       nreset;
    logic       sck;
    logic       mosi;
    logic       ncs;
    logic [1:0] freq_in = 2'b00;
    logic       miso;
    logic       interrupt;
    logic [3:0] dds_out;
    logic [3:0] pwm_out;

    integer seed;
    int     test_errors = 0;
    int     errors = 0;
    int     passed = 0;
    int     failed = 0;
    int     div0 = 0;
    int     div1 = 0;

    tb_clock clock0 (.clk(clk), .nreset(nreset));

    siggen_top #(.MCLK(MCLK), .FCLK(FCLK)) dut0 (
        .clk       (clk),
        .nreset    (nreset),
        .sck       (sck),
        .mosi      (mosi),
        .ncs       (ncs),
        .freq_in   (freq_in),
        .miso      (miso),
        .interrupt (interrupt),
        .dds_out   (dds_out),
        .pwm_out   (pwm_out)
    );

    // two square waves for the counters
    always @(posedge clk) begin
        #10;
        div0 = (div0 == per0 - 1) ? 0 : div0 + 1;
        div1 = (div1 == per1 - 1) ? 0 : div1 + 1;
        freq_in = {div1 < per1 / 2, div0 < per0 / 2};
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < max_cycles) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run stopped after %0d clock cycles", cycles);
        $display("SOME TESTS FAILED");
        $finish;
    end

    task automatic wait_clks(input int n);
        repeat (n) @(posedge clk);
        #10;
    endtask

    // one framed transfer msb first with miso sampled just before each rising sck
    task automatic spi_xfer(input logic [119:0] tx, input int nbytes,
                            output logic [119:0] rx);
        rx = '0;
        ncs = 1'b0;
        wait_clks(half_clks);
        for (int i = 0; i < 8 * nbytes; i++) begin
            mosi = tx[119 - i];
            wait_clks(half_clks);
            rx[119 - i] = miso;
            sck = 1'b1;
            wait_clks(half_clks);
            sck = 1'b0;
        end
        wait_clks(half_clks);
        ncs = 1'b1;
        mosi = 1'b0;
        wait_clks(half_clks);
    endtask

    // 15-byte dummy frame of a length the DUT ignores
    task automatic read_response(output logic [119:0] rx);
        spi_xfer('0, 15, rx);
    endtask

    function automatic logic [119:0] cmd_query(input logic [7:0] op, input logic [7:0] sub);
        return {op, sub, 104'h0};
    endfunction

    function automatic logic [119:0] cmd_enable(input logic [7:0] dev, input logic [7:0] grp,
                                                input chan_t ch, input logic [7:0] on);
        return {dev, grp, act_enable, 6'h0, ch, on, 80'h0};
    endfunction

    // period field is 3 bytes wide
    function automatic logic [119:0] cmd_set_duty(input chan_t ch, input word_t period,
                                                  input word_t duty);
        return {dev_pwm, grp_device, act_set, 6'h0, ch, period[23:0], duty, 32'h0};
    endfunction

    function automatic logic [119:0] cmd_set_freq(input chan_t ch, input word_t code);
        return {dev_dds, grp_device, act_set, 6'h0, ch, code, 56'h0};
    endfunction

    function automatic logic [119:0] expect_response(input logic [119:0] cmd, input int nbytes);
        logic [7:0]   r [15];
        logic [7:0]   op;
        logic [7:0]   sub;
        logic [119:0] v;
        op = cmd[119:112];
        sub = cmd[111:104];
        for (int i = 0; i < 15; i++)
            r[i] = 8'h00;
        if (nbytes == 2) begin
            if (op == op_get_id) begin
                {r[0], r[1], r[2], r[3]} = device_id_word;
            end else if (op == op_get_config && sub == dev_dds) begin
                {r[0], r[1]} = dds_type;
                {r[8], r[9], r[10], r[11]} = MCLK;    // low half of a 64-bit field
                {r[12], r[13]} = max_mv;
            end else if (op == op_get_config && sub == dev_pwm) begin
                {r[0], r[1], r[2], r[3]} = MCLK;
                r[4] = pwm_channels;
                r[5] = pwm_bits;
            end else if (op == op_get_config && sub == dev_fc) begin
                r[0] = fc_channels;
                r[1] = fc_resolution;
                r[2] = fc_measure_type;
                r[4] = fc_digits;
            end else if (op == op_get_result) begin
                {r[0], r[1], r[2], r[3]} = 32'(FCLK / per0);
                {r[4], r[5], r[6], r[7]} = 32'(FCLK / per1);
            end
        end
        for (int i = 0; i < 15; i++)
            v[119 - 8 * i -: 8] = r[i];
        return v;
    endfunction

    // tol > 0 compares the two leading words as counts
    task automatic check_response(input string what, input logic [119:0] got,
                                  input logic [119:0] exp, input int tol);
        word_t g;
        word_t e;
        int    first;
        first = 0;
        if (tol > 0) begin
            for (int w = 0; w < 2; w++) begin
                g = got[119 - 32 * w -: 32];
                e = exp[119 - 32 * w -: 32];
                if (g + word_t'(tol) < e || g > e + word_t'(tol)) begin
                    $display("ERR count%0d (%s): got %h expected %h", w, what, g, e);
                    test_errors++;
                end
            end
            first = 8;
        end
        for (int k = first; k < 15; k++) begin
            if (got[119 - 8 * k -: 8] !== exp[119 - 8 * k -: 8]) begin
                $display("ERR miso byte %0d (%s): got %h expected %h", k, what,
                         got[119 - 8 * k -: 8], exp[119 - 8 * k -: 8]);
                test_errors++;
            end
        end
    endtask

    task automatic run_query(input logic [7:0] op, input logic [7:0] sub, input string what);
        logic [119:0] cmd;
        logic [119:0] rx;
        cmd = cmd_query(op, sub);
        spi_xfer(cmd, 2, rx);
        read_response(rx);
        check_response(what, rx, expect_response(cmd, 2), 0);
    endtask

    task automatic check_dds_steady(input chan_t ch, input int n);
        logic first;
        first = dds_out[ch];
        for (int t = 0; t < n; t++) begin
            wait_clks(1);
            if (dds_out[ch] !== first) begin
                $display("ERR dds_out[%0d]: got %h expected %h", ch, dds_out[ch], first);
                test_errors++;
                break;
            end
        end
    endtask

    task automatic check_dds_period(input chan_t ch, input int period);
        int   last_rise;
        int   rises;
        logic prev;
        last_rise = -1;
        rises = 0;
        prev = dds_out[ch];
        for (int t = 0; t < 6 * period; t++) begin
            wait_clks(1);
            if (dds_out[ch] && !prev) begin
                if (last_rise >= 0 && t - last_rise != period) begin
                    $display("ERR dds_out[%0d] rise spacing: got %h expected %h",
                             ch, t - last_rise, period);
                    test_errors++;
                end
                last_rise = t;
                rises++;
            end
            prev = dds_out[ch];
        end
        if (rises < 4) begin
            $display("dds_out[%0d] showed only %0d rising edges after enable", ch, rises);
            test_errors++;
        end
    endtask

    task automatic check_pwm_high(input chan_t ch, input int n, input int expected);
        int high;
        high = 0;
        for (int t = 0; t < n; t++) begin
            wait_clks(1);
            if (pwm_out[ch])
                high++;
        end
        if (high != expected) begin
            $display("ERR pwm_out[%0d] high cycles: got %h expected %h", ch, high, expected);
            test_errors++;
        end
    endtask

    task automatic wait_interrupt(input logic level, input int limit, output bit ok);
        int t;
        t = 0;
        while (interrupt !== level && t < limit) begin
            wait_clks(1);
            t++;
        end
        ok = (interrupt === level);
    endtask

    task automatic finish_test(input string name);
        if (test_errors == 0) begin
            passed++;
            $display("test %s: pass", name);
        end else begin
            failed++;
            $display("test %s: fail with %0d errors", name, test_errors);
        end
        errors += test_errors;
        test_errors = 0;
    endtask

    initial begin : main
        logic [119:0] cmd;
        logic [119:0] rx;
        chan_t        dch;
        chan_t        pch;
        word_t        period;
        word_t        duty;
        bit           ok;
        seed = 32'h0a84_d438;
        sck = 1'b0;
        mosi = 1'b0;
        ncs = 1'b1;
        wait (nreset === 1'b1);
        wait_clks(2);

        run_query(op_get_id, 8'h00, "get id");
        run_query(op_get_config, dev_dds, "config dds");
        run_query(op_get_config, dev_pwm, "config pwm");
        run_query(op_get_config, dev_fc, "config fc");
        run_query(8'h07, 8'h00, "status");
        finish_test("queries");

        dch = chan_t'($random(seed));
        spi_xfer(cmd_set_freq(dch, dds_test_code), 14, rx);
        check_dds_steady(dch, 64);    // still disabled
        spi_xfer(cmd_enable(dev_dds, grp_device, dch, 8'h01), 5, rx);
        check_dds_period(dch, int'((64'd1 << 32) / dds_test_code));
        spi_xfer(cmd_enable(dev_dds, grp_device, dch, 8'h00), 5, rx);
        check_dds_steady(dch, 64);
        finish_test("dds");

        pch = chan_t'($random(seed));
        period = 8 + ($random(seed) & 7);
        duty = 1 + ($unsigned($random(seed)) % (period - 1));
        spi_xfer(cmd_set_duty(pch, period, duty), 11, rx);
        check_pwm_high(pch, 3 * int'(period), 0);
        spi_xfer(cmd_enable(dev_pwm, grp_device, pch, 8'h01), 5, rx);
        wait_clks(int'(period));
        check_pwm_high(pch, 4 * int'(period), 4 * int'(duty));
        period = 12 + ($random(seed) & 7);
        duty = 1 + ($unsigned($random(seed)) % (period - 1));
        spi_xfer(cmd_set_duty(pch, period, duty), 11, rx);
        wait_clks(2 * int'(period));
        check_pwm_high(pch, 4 * int'(period), 4 * int'(duty));
        finish_test("pwm");

        cmd = cmd_query(op_get_result, 8'h00);
        wait_interrupt(1'b1, 2 * FCLK + 20, ok);
        // a clear that lands on a gate end is lost, so retry
        for (int k = 0; k < 3 && interrupt; k++)
            spi_xfer(cmd, 2, rx);
        if (interrupt !== 1'b0) begin
            $display("interrupt did not clear after a get result frame");
            test_errors++;
        end
        wait_interrupt(1'b1, FCLK + 20, ok);
        if (!ok) begin
            $display("interrupt did not rise within one gate");
            test_errors++;
        end
        spi_xfer(cmd, 2, rx);    // query frame is shorter than a gate
        if (interrupt !== 1'b0) begin
            $display("ERR interrupt: got %h expected %h", interrupt, 1'b0);
            test_errors++;
        end
        read_response(rx);
        check_response("get result", rx, expect_response(cmd, 2), 1);
        finish_test("freq counter");

        cmd = cmd_enable(dev_dds, 8'h07, dch, 8'h01);
        spi_xfer(cmd, 5, rx);
        check_dds_steady(dch, 64);
        read_response(rx);
        check_response("bad group", rx, expect_response(cmd, 5), 0);
        finish_test("bad frame");

        $display("tests: %0d passed, %0d failed, %0d errors", passed, failed, errors);
        if (failed == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: dv/tb_clock.sv
`default_nettype none

module tb_clock (
    output logic clk,
    output logic nreset
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;    // period 100
    end

    initial begin
        nreset = 1'b0;
        repeat (3) @(posedge clk);
        #10;
        nreset = 1'b1;
    end

endmodule

`default_nettype wire

// File: design/siggen_top.sv
`default_nettype none

module siggen_top
    import siggen_pkg::*;
#(
    parameter logic [31:0] MCLK = 32'd270_000_000,
    parameter int          FCLK = 27_000_000
)(
    input  logic              clk,
    input  logic              nreset,
    input  logic              sck,
    input  logic              mosi,
    input  logic              ncs,
    input  logic [1:0]        freq_in,
    output logic              miso,
    output logic              interrupt,
    output logic [num_ch-1:0] dds_out,
    output logic [num_ch-1:0] pwm_out
);

    word_t dds_code [num_ch];
    word_t pwm_period [num_ch];
    word_t pwm_duty [num_ch];
    word_t count0;
    word_t count1;
    logic  ready0;
    logic  ready1;
    logic  irq_clear;

    spi_frame_if frame ();

    assign interrupt = ready0 & ready1;    // both gates done

    spi_slave u_spi (
        .clk    (clk),
        .nreset (nreset),
        .sck    (sck),
        .mosi   (mosi),
        .ncs    (ncs),
        .miso   (miso),
        .frame  (frame.slave)
    );

    command_decoder #(.MCLK(MCLK)) u_dec (
        .clk        (clk),
        .nreset     (nreset),
        .count0     (count0),
        .count1     (count1),
        .ready0     (ready0),
        .ready1     (ready1),
        .frame      (frame.decoder),
        .dds_code   (dds_code),
        .pwm_period (pwm_period),
        .pwm_duty   (pwm_duty),
        .irq_clear  (irq_clear)
    );

    dds_bank u_dds (
        .clk      (clk),
        .nreset   (nreset),
        .dds_code (dds_code),
        .dds_out  (dds_out)
    );

    pwm_bank u_pwm (
        .clk        (clk),
        .nreset     (nreset),
        .pwm_period (pwm_period),
        .pwm_duty   (pwm_duty),
        .pwm_out    (pwm_out)
    );

    freq_counter #(.FCLK(FCLK)) u_fc0 (
        .clk       (clk),
        .nreset    (nreset),
        .sig       (freq_in[0]),
        .irq_clear (irq_clear),
        .count     (count0),
        .ready     (ready0)
    );

    freq_counter #(.FCLK(FCLK)) u_fc1 (
        .clk       (clk),
        .nreset    (nreset),
        .sig       (freq_in[1]),
        .irq_clear (irq_clear),
        .count     (count1),
        .ready     (ready1)
    );

endmodule

`default_nettype wire

// File: design/freq_counter.sv
`default_nettype none

module freq_counter
    import siggen_pkg::*;
#(
    parameter int FCLK = 27_000_000
)(
    input  logic  clk,
    input  logic  nreset,
    input  logic  sig,
    input  logic  irq_clear,
    output word_t count,
    output logic  ready
);

    logic [1:0] sig_sync;
    logic       sig_prev;
    logic       sig_rise;
    logic       gate_end;
    word_t      gate_cnt;
    word_t      edge_cnt;

    assign sig_rise = sig_sync[1] & ~sig_prev;
    assign gate_end = gate_cnt == word_t'(FCLK - 1);

    always_ff @(posedge clk) begin
        if (!nreset) begin
            sig_sync <= '0;
            sig_prev <= 1'b0;
            gate_cnt <= '0;
            edge_cnt <= '0;
            count    <= '0;
            ready    <= 1'b0;
        end else begin
            sig_sync <= {sig_sync[0], sig};
            sig_prev <= sig_sync[1];
            if (gate_end) begin
                gate_cnt <= '0;
                edge_cnt <= '0;
                count    <= edge_cnt + word_t'(sig_rise);    // overwrites unread result
                ready    <= 1'b1;
            end else begin
                gate_cnt <= gate_cnt + 32'd1;
                if (sig_rise)
                    edge_cnt <= edge_cnt + 32'd1;
                if (irq_clear)
                    ready <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/pwm_bank.sv
`default_nettype none

module pwm_bank
    import siggen_pkg::*;
(
    input  logic              clk,
    input  logic              nreset,
    input  word_t             pwm_period [num_ch],
    input  word_t             pwm_duty [num_ch],
    output logic [num_ch-1:0] pwm_out
);

    word_t cnt [num_ch];
    word_t period_eff [num_ch];

    for (genvar i = 0; i < num_ch; i++) begin : g_ch
        assign period_eff[i] = (pwm_period[i] == '0) ? 32'd1 : pwm_period[i];
        assign pwm_out[i]    = cnt[i] < pwm_duty[i];

        always_ff @(posedge clk) begin
            if (!nreset)
                cnt[i] <= '0;
            else if (cnt[i] >= period_eff[i] - 32'd1)
                cnt[i] <= '0;    // also catches a shortened period
            else
                cnt[i] <= cnt[i] + 32'd1;
        end

        // a new period is seen one cycle late
        a_cnt_in_period: assert property (@(posedge clk) disable iff (!nreset)
            cnt[i] < $past(period_eff[i]));
    end

endmodule

`default_nettype wire

// File: design/dds_bank.sv
`default_nettype none

module dds_bank
    import siggen_pkg::*;
(
    input  logic              clk,
    input  logic              nreset,
    input  word_t             dds_code [num_ch],
    output logic [num_ch-1:0] dds_out
);

    word_t acc [num_ch];

    for (genvar i = 0; i < num_ch; i++) begin : g_ch
        assign dds_out[i] = acc[i][31];    // square wave from phase msb

        always_ff @(posedge clk) begin
            if (!nreset)
                acc[i] <= '0;
            else
                acc[i] <= acc[i] + dds_code[i];
        end
    end

endmodule

`default_nettype wire

// File: design/command_decoder.sv
`default_nettype none

module command_decoder
    import siggen_pkg::*;
#(
    parameter logic [31:0] MCLK = 32'd270_000_000
)(
    input  logic          clk,
    input  logic          nreset,
    input  word_t         count0,
    input  word_t         count1,
    input  logic          ready0,
    input  logic          ready1,
    spi_frame_if.decoder  frame,
    output word_t         dds_code [num_ch],
    output word_t         pwm_period [num_ch],
    output word_t         pwm_duty [num_ch],
    output logic          irq_clear
);

    word_t                  dds_shadow [num_ch];
    word_t                  duty_shadow [num_ch];
    logic [num_ch-1:0]      dds_en;
    logic [num_ch-1:0]      pwm_en;
    logic [cmd_len_max-1:0] cmd;
    logic [cmd_len_max-1:0] query_resp;
    chan_t                  en_ch;
    chan_t                  duty_ch;
    chan_t                  freq_ch;
    logic                   en_on;
    word_t                  new_period;
    word_t                  new_duty;
    word_t                  new_code;

    // byte k of a len-bit frame, k = 0 is the first byte sent
    function automatic logic [7:0] frame_byte(input logic [cmd_len_max-1:0] c,
                                              input int len, input int k);
        return c[len - 1 - 8 * k -: 8];
    endfunction

    function automatic word_t frame_word(input logic [cmd_len_max-1:0] c,
                                         input int len, input int k);
        return c[len - 1 - 8 * k -: 32];
    endfunction

    function automatic logic hdr_ok(input logic [cmd_len_max-1:0] c,
                                    input int len, input logic [7:0] act);
        return frame_byte(c, len, 1) == grp_device && frame_byte(c, len, 2) == act;
    endfunction

    assign cmd        = frame.command;
    assign en_ch      = chan_t'(frame_byte(cmd, len_enable, 3));
    assign en_on      = frame_byte(cmd, len_enable, 4) != 8'h00;
    // 11-byte frame: byte 3 selects the channel, period is the 24 bits after it
    assign duty_ch    = chan_t'(frame_byte(cmd, len_set_duty, 3));
    assign new_period = frame_word(cmd, len_set_duty, 3) & 32'h00ff_ffff;
    assign new_duty   = frame_word(cmd, len_set_duty, 7);
    assign freq_ch    = chan_t'(frame_byte(cmd, len_set_freq, 3));
    assign new_code   = frame_word(cmd, len_set_freq, 4);    // padding follows

    always_comb begin
        query_resp = '0;
        case (frame_byte(cmd, len_query, 0))
            op_get_id:     query_resp = {device_id_word, 88'h0};
            op_get_config: begin
                case (frame_byte(cmd, len_query, 1))
                    dev_dds: query_resp = {dds_type, 16'h0, 32'h0, MCLK, max_mv, 8'h0};
                    dev_pwm: query_resp = {MCLK, pwm_channels, pwm_bits, 8'h0, 64'h0};
                    dev_fc:  query_resp = {fc_channels, fc_resolution, fc_measure_type,
                                           8'h0, fc_digits, 80'h0};
                    default: query_resp = '0;
                endcase
            end
            op_get_result: query_resp = {count0, count1, 56'h0};
            default:       query_resp = '0;    // status
        endcase
    end

    always_ff @(posedge clk) begin
        if (!nreset) begin
            for (int i = 0; i < num_ch; i++) begin
                dds_code[i]    <= '0;
                dds_shadow[i]  <= '0;
                pwm_period[i]  <= 32'd1;
                pwm_duty[i]    <= '0;
                duty_shadow[i] <= '0;
            end
            dds_en              <= '0;
            pwm_en              <= '0;
            irq_clear           <= 1'b0;
            frame.response      <= '0;
            frame.response_load <= 1'b0;
        end else begin
            frame.response_load <= frame.frame_done;
            irq_clear           <= 1'b0;
            if (frame.frame_done) begin
                frame.response <= '0;
                case (frame.bit_count)
                    len_query: begin
                        frame.response <= query_resp;
                        if (frame_byte(cmd, len_query, 0) == op_get_result)
                            irq_clear <= ready0 | ready1;    // only when a result waits
                    end
                    len_enable: begin
                        if (hdr_ok(cmd, len_enable, act_enable)) begin
                            if (frame_byte(cmd, len_enable, 0) == dev_dds) begin
                                dds_en[en_ch]   <= en_on;
                                dds_code[en_ch] <= en_on ? dds_shadow[en_ch] : '0;
                            end else if (frame_byte(cmd, len_enable, 0) == dev_pwm) begin
                                pwm_en[en_ch]   <= en_on;
                                pwm_duty[en_ch] <= en_on ? duty_shadow[en_ch] : '0;
                            end
                        end
                    end
                    len_set_duty: begin
                        if (hdr_ok(cmd, len_set_duty, act_set)) begin
                            pwm_period[duty_ch]  <= new_period;
                            duty_shadow[duty_ch] <= new_duty;
                            if (pwm_en[duty_ch])
                                pwm_duty[duty_ch] <= new_duty;
                        end
                    end
                    len_set_freq: begin
                        if (hdr_ok(cmd, len_set_freq, act_set)) begin
                            dds_shadow[freq_ch] <= new_code;
                            if (dds_en[freq_ch])
                                dds_code[freq_ch] <= new_code;
                        end
                    end
                    default: ;    // unknown length, zero response
                endcase
            end
        end
    end

    a_irq_clear_pulse: assert property (@(posedge clk) disable iff (!nreset)
        irq_clear |=> !irq_clear);

endmodule

`default_nettype wire

// File: design/spi_slave.sv
`default_nettype none

module spi_slave
    import siggen_pkg::*;
(
    input  logic       clk,
    input  logic       nreset,
    input  logic       sck,
    input  logic       mosi,
    input  logic       ncs,
    output logic       miso,
    spi_frame_if.slave frame
);

    logic [1:0]             sck_sync;
    logic [1:0]             mosi_sync;
    logic [1:0]             ncs_sync;
    logic                   sck_prev;
    logic                   ncs_prev;
    logic                   sck_rise;
    logic                   sck_fall;
    logic                   selected;
    logic [cmd_len_max-1:0] shift_out;

    assign selected = ~ncs_sync[1];
    assign sck_rise = sck_sync[1] & ~sck_prev;
    assign sck_fall = ~sck_sync[1] & sck_prev;
    assign miso     = selected ? shift_out[cmd_len_max-1] : 1'b0;

    always_ff @(posedge clk) begin
        if (!nreset) begin
            sck_sync         <= '0;
            mosi_sync        <= '0;
            ncs_sync         <= 2'b11;
            sck_prev         <= 1'b0;
            ncs_prev         <= 1'b1;
            shift_out        <= '0;
            frame.bit_count  <= '0;
            frame.frame_done <= 1'b0;
        end else begin
            sck_sync         <= {sck_sync[0], sck};
            mosi_sync        <= {mosi_sync[0], mosi};
            ncs_sync         <= {ncs_sync[0], ncs};
            sck_prev         <= sck_sync[1];
            ncs_prev         <= ncs_sync[1];
            frame.frame_done <= ncs_sync[1] & ~ncs_prev;    // deselect edge

            if (frame.response_load) begin
                shift_out       <= frame.response;
                frame.bit_count <= '0;
            end else if (selected && sck_rise) begin
                frame.bit_count <= frame.bit_count + 8'd1;
            end else if (selected && sck_fall) begin
                shift_out <= {shift_out[cmd_len_max-2:0], 1'b0};
            end
        end
    end

    // mosi shift register
    always_ff @(posedge clk) begin
        if (selected && sck_rise)
            frame.command <= {frame.command[cmd_len_max-2:0], mosi_sync[1]};
    end

    // decoder answers exactly one cycle after the frame end
    a_load_after_done: assert property (@(posedge clk) disable iff (!nreset)
        frame.response_load |-> $past(frame.frame_done));

endmodule

`default_nettype wire

// File: design/spi_frame_if.sv
`default_nettype none

interface spi_frame_if
    import siggen_pkg::*;
();

    logic [cmd_len_max-1:0] command;   // newest bit at lsb
    logic [7:0]             bit_count;
    logic                   frame_done;
    logic [cmd_len_max-1:0] response;
    logic                   response_load;

    modport slave (
        output command, bit_count, frame_done,
        input  response, response_load
    );

    modport decoder (
        input  command, bit_count, frame_done,
        output response, response_load
    );

endinterface

`default_nettype wire

// File: design/siggen_pkg.sv
`default_nettype none

package siggen_pkg;

    localparam int cmd_len_max = 120;          // 15 bytes

    // frame length in bits picks the command
    localparam logic [7:0] len_query    = 8'd16;
    localparam logic [7:0] len_enable   = 8'd40;
    localparam logic [7:0] len_set_duty = 8'd88;
    localparam logic [7:0] len_set_freq = 8'd112;

    localparam logic [7:0] op_get_id     = 8'd0;
    localparam logic [7:0] op_get_config = 8'd1;
    localparam logic [7:0] op_get_result = 8'd4;

    localparam logic [7:0] dev_dds = 8'd0;
    localparam logic [7:0] dev_pwm = 8'd1;
    localparam logic [7:0] dev_fc  = 8'd2;

    localparam logic [7:0] grp_device = 8'd3;
    localparam logic [7:0] act_set    = 8'd2;
    localparam logic [7:0] act_enable = 8'd5;

    localparam logic [31:0] device_id_word = 32'h0104_0200;

    localparam logic [15:0] dds_type        = 16'd6;
    localparam logic [15:0] max_mv          = 16'd3300;
    localparam logic [7:0]  pwm_channels    = 8'd4;
    localparam logic [7:0]  pwm_bits        = 8'd32;
    localparam logic [7:0]  fc_channels     = 8'd2;
    localparam logic [7:0]  fc_resolution   = 8'd4;
    localparam logic [7:0]  fc_measure_type = 8'd6;    // hertz
    localparam logic [7:0]  fc_digits       = 8'd9;

    localparam int num_ch = 4;

    typedef logic [1:0]  chan_t;
    typedef logic [31:0] word_t;

endpackage

`default_nettype wire
